// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/core_pkg.sv ====
package core_pkg;

    ///////////////////////////////////////////////////////////////////////
    // datapath types
    localparam int data_width = 32;

    typedef logic [data_width-1:0] word_t;
    typedef logic [3:0]            reg_addr_t;

    localparam word_t reset_pc = '0;
    localparam word_t pc_step  = 32'd4;

    // reads as zero, writes to it are dropped
    localparam reg_addr_t zero_reg_read = 4'd15;

    ///////////////////////////////////////////////////////////////////////
    // instruction fields
    localparam int op_msb    = 27;
    localparam int op_lsb    = 26;
    localparam int imm_bit   = 25;
    localparam int cmd_msb   = 24;
    localparam int cmd_lsb   = 21;
    localparam int load_bit  = 20;
    localparam int rn_msb    = 19;
    localparam int rn_lsb    = 16;
    localparam int rd_msb    = 15;
    localparam int rd_lsb    = 12;
    localparam int rm_msb    = 3;
    localparam int rm_lsb    = 0;
    localparam int imm8_msb  = 7;
    localparam int imm12_msb = 11;
    localparam int imm_lsb   = 0;

    localparam logic [1:0] op_data   = 2'b00;
    localparam logic [1:0] op_memory = 2'b01;

    localparam logic [3:0] cmd_and = 4'b0000;
    localparam logic [3:0] cmd_sub = 4'b0010;
    localparam logic [3:0] cmd_add = 4'b0100;
    localparam logic [3:0] cmd_orr = 4'b1100;
    localparam logic [3:0] cmd_mov = 4'b1101;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_orr,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_memory,
        fwd_from_writeback
    } forward_sel_t;

endpackage

// ==== source/decode_stage.sv ====
module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  core_pkg::word_t     instr_d,
    input  logic                wb_write_enable,
    input  core_pkg::reg_addr_t wb_write_addr,
    input  core_pkg::word_t     wb_result,
    output core_pkg::reg_addr_t src_a_idx_d,
    output core_pkg::reg_addr_t src_b_idx_d,
    output logic                reg_write_e,
    output logic                mem_write_e,
    output logic                mem_to_reg_e,
    output logic                alu_src_imm_e,
    output core_pkg::alu_op_t   alu_op_e,
    output core_pkg::word_t     operand_a_e,
    output core_pkg::word_t     operand_b_e,
    output core_pkg::word_t     imm_e,
    output core_pkg::reg_addr_t src_a_idx_e,
    output core_pkg::reg_addr_t src_b_idx_e,
    output core_pkg::reg_addr_t dest_e
);

    logic [1:0]          op;
    logic [3:0]          cmd;
    core_pkg::reg_addr_t rn;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rm;
    logic                imm_form;
    logic                cmd_known;
    logic                is_data;
    logic                is_mem;
    logic                is_load;
    logic                is_store;
    logic                reg_write;
    core_pkg::alu_op_t   data_op;
    core_pkg::alu_op_t   alu_op;
    core_pkg::word_t     imm;
    core_pkg::word_t     read_data_a;
    core_pkg::word_t     read_data_b;

    assign op       = instr_d[core_pkg::op_msb:core_pkg::op_lsb];
    assign cmd      = instr_d[core_pkg::cmd_msb:core_pkg::cmd_lsb];
    assign rn       = instr_d[core_pkg::rn_msb:core_pkg::rn_lsb];
    assign rd       = instr_d[core_pkg::rd_msb:core_pkg::rd_lsb];
    assign rm       = instr_d[core_pkg::rm_msb:core_pkg::rm_lsb];
    assign imm_form = instr_d[core_pkg::imm_bit];

    ///////////////////////////////////////////////////////////////////////
    // control decode
    always_comb begin
        cmd_known = 1'b1;
        case (cmd)
            core_pkg::cmd_and: data_op = core_pkg::alu_and;
            core_pkg::cmd_sub: data_op = core_pkg::alu_sub;
            core_pkg::cmd_add: data_op = core_pkg::alu_add;
            core_pkg::cmd_orr: data_op = core_pkg::alu_orr;
            core_pkg::cmd_mov: data_op = core_pkg::alu_pass_b;
            default: begin
                data_op   = core_pkg::alu_add;
                cmd_known = 1'b0;
            end
        endcase
    end

    assign is_data  = (op == core_pkg::op_data) && cmd_known;
    assign is_mem   = (op == core_pkg::op_memory);
    assign is_load  = is_mem && instr_d[core_pkg::load_bit];
    assign is_store = is_mem && !instr_d[core_pkg::load_bit];
    // address calculation is always base plus offset
    assign alu_op   = is_data ? data_op : core_pkg::alu_add;

    // r15 as destination turns the instruction into a no-op
    assign reg_write = (is_data || is_load) && (rd != core_pkg::zero_reg_read);

    // unused sources point at r15 so they never match a hazard
    assign src_a_idx_d = (is_mem || (is_data && cmd != core_pkg::cmd_mov)) ?
                         rn : core_pkg::zero_reg_read;
    assign src_b_idx_d = is_store ? rd :
                         (is_data && !imm_form) ? rm : core_pkg::zero_reg_read;

    assign imm = is_mem ? core_pkg::word_t'(instr_d[core_pkg::imm12_msb:core_pkg::imm_lsb])
                        : core_pkg::word_t'(instr_d[core_pkg::imm8_msb:core_pkg::imm_lsb]);

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .read_addr_a  (src_a_idx_d),
        .read_addr_b  (src_b_idx_d),
        .write_enable (wb_write_enable),
        .write_addr   (wb_write_addr),
        .write_data   (wb_result),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b)
    );

    ///////////////////////////////////////////////////////////////////////
    // decode to execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
        end else if (stall) begin
            // bubble
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
        end else begin
            reg_write_e  <= reg_write;
            mem_write_e  <= is_store;
            mem_to_reg_e <= is_load && reg_write;
        end
    end

    always_ff @(posedge clk) begin
        alu_src_imm_e <= (is_data && imm_form) || is_mem;
        alu_op_e      <= alu_op;
        operand_a_e   <= read_data_a;
        operand_b_e   <= read_data_b;
        imm_e         <= imm;
        src_a_idx_e   <= src_a_idx_d;
        src_b_idx_e   <= src_b_idx_d;
        dest_e        <= rd;
    end

endmodule

// ==== source/execute_stage.sv ====
module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   reg_write_e,
    input  logic                   mem_write_e,
    input  logic                   mem_to_reg_e,
    input  logic                   alu_src_imm_e,
    input  core_pkg::alu_op_t      alu_op_e,
    input  core_pkg::word_t        operand_a_e,
    input  core_pkg::word_t        operand_b_e,
    input  core_pkg::word_t        imm_e,
    input  core_pkg::reg_addr_t    dest_e,
    input  core_pkg::forward_sel_t forward_a,
    input  core_pkg::forward_sel_t forward_b,
    input  core_pkg::word_t        alu_result_m_fwd,
    input  core_pkg::word_t        result_w_fwd,
    output logic                   reg_write_m,
    output logic                   mem_write_m,
    output logic                   mem_to_reg_m,
    output core_pkg::word_t        alu_result_m,
    output core_pkg::word_t        store_data_m,
    output core_pkg::reg_addr_t    dest_m
);

    core_pkg::word_t src_a;
    core_pkg::word_t src_b;
    core_pkg::word_t alu_b;
    core_pkg::word_t alu_result;

    // forwarding muxes
    always_comb begin
        case (forward_a)
            core_pkg::fwd_from_memory:    src_a = alu_result_m_fwd;
            core_pkg::fwd_from_writeback: src_a = result_w_fwd;
            default:                      src_a = operand_a_e;
        endcase
        case (forward_b)
            core_pkg::fwd_from_memory:    src_b = alu_result_m_fwd;
            core_pkg::fwd_from_writeback: src_b = result_w_fwd;
            default:                      src_b = operand_b_e;
        endcase
    end

    // src_b is also the store data, before the immediate select
    assign alu_b = alu_src_imm_e ? imm_e : src_b;

    always_comb begin
        case (alu_op_e)
            core_pkg::alu_add: alu_result = src_a + alu_b;
            core_pkg::alu_sub: alu_result = src_a - alu_b;
            core_pkg::alu_and: alu_result = src_a & alu_b;
            core_pkg::alu_orr: alu_result = src_a | alu_b;
            default:           alu_result = alu_b;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            mem_to_reg_m <= mem_to_reg_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m <= alu_result;
        store_data_m <= src_b;
        dest_m       <= dest_e;
    end

endmodule

// ==== source/fetch_stage.sv ====
module fetch_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  core_pkg::word_t imem_data,
    output core_pkg::word_t imem_addr,
    output core_pkg::word_t instr_d
);

    core_pkg::word_t pc;

    assign imem_addr = pc;

    // pc and decode instruction both freeze on a load-use stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= core_pkg::reset_pc;
            instr_d <= '0;
        end else if (!stall) begin
            pc      <= pc + core_pkg::pc_step;
            instr_d <= imem_data;
        end
    end

endmodule

// ==== source/hazard_unit.sv ====
module hazard_unit (
    input  core_pkg::reg_addr_t    src_a_idx_d,
    input  core_pkg::reg_addr_t    src_b_idx_d,
    input  core_pkg::reg_addr_t    src_a_idx_e,
    input  core_pkg::reg_addr_t    src_b_idx_e,
    input  core_pkg::reg_addr_t    dest_e,
    input  core_pkg::reg_addr_t    dest_m,
    input  core_pkg::reg_addr_t    dest_w,
    input  logic                   mem_to_reg_e,
    input  logic                   reg_write_m,
    input  logic                   reg_write_w,
    output logic                   stall,
    output core_pkg::forward_sel_t forward_a,
    output core_pkg::forward_sel_t forward_b
);

    // youngest producer wins
    function automatic core_pkg::forward_sel_t pick_source(
        input core_pkg::reg_addr_t src,
        input logic                rw_m,
        input core_pkg::reg_addr_t d_m,
        input logic                rw_w,
        input core_pkg::reg_addr_t d_w
    );
        if (rw_m && d_m == src) begin
            return core_pkg::fwd_from_memory;
        end
        if (rw_w && d_w == src) begin
            return core_pkg::fwd_from_writeback;
        end
        return core_pkg::fwd_none;
    endfunction

    assign forward_a = pick_source(src_a_idx_e, reg_write_m, dest_m, reg_write_w, dest_w);
    assign forward_b = pick_source(src_b_idx_e, reg_write_m, dest_m, reg_write_w, dest_w);

    // load result not ready until writeback
    assign stall = mem_to_reg_e && (dest_e == src_a_idx_d || dest_e == src_b_idx_d);

endmodule

// ==== source/memory_writeback.sv ====
module memory_writeback (
    input  logic                clk,
    input  logic                reset,
    input  logic                reg_write_m,
    input  logic                mem_to_reg_m,
    input  core_pkg::reg_addr_t dest_m,
    input  core_pkg::word_t     alu_result_m,
    input  core_pkg::word_t     dmem_rdata,
    output logic                reg_write_w,
    output core_pkg::reg_addr_t dest_w,
    output core_pkg::word_t     result_w
);

    logic            mem_to_reg_w;
    core_pkg::word_t load_data_w;
    core_pkg::word_t alu_result_w;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    // dmem_rdata is already valid for the address on the memory stage
    always_ff @(posedge clk) begin
        load_data_w  <= dmem_rdata;
        alu_result_w <= alu_result_m;
        dest_w       <= dest_m;
    end

    assign result_w = mem_to_reg_w ? load_data_w : alu_result_w;

endmodule

// ==== source/pipeline_core.sv ====
module pipeline_core (
    input  logic            clk,
    input  logic            reset,
    output core_pkg::word_t imem_addr,
    input  core_pkg::word_t imem_data,
    output core_pkg::word_t dmem_addr,
    output core_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    input  core_pkg::word_t dmem_rdata
);

    logic                   stall;
    core_pkg::word_t        instr_d;
    core_pkg::reg_addr_t    src_a_idx_d;
    core_pkg::reg_addr_t    src_b_idx_d;
    logic                   reg_write_e;
    logic                   mem_write_e;
    logic                   mem_to_reg_e;
    logic                   alu_src_imm_e;
    core_pkg::alu_op_t      alu_op_e;
    core_pkg::word_t        operand_a_e;
    core_pkg::word_t        operand_b_e;
    core_pkg::word_t        imm_e;
    core_pkg::reg_addr_t    src_a_idx_e;
    core_pkg::reg_addr_t    src_b_idx_e;
    core_pkg::reg_addr_t    dest_e;
    core_pkg::forward_sel_t forward_a;
    core_pkg::forward_sel_t forward_b;
    logic                   reg_write_m;
    logic                   mem_to_reg_m;
    core_pkg::word_t        alu_result_m;
    core_pkg::reg_addr_t    dest_m;
    logic                   reg_write_w;
    core_pkg::reg_addr_t    dest_w;
    core_pkg::word_t        result_w;

    assign dmem_addr = alu_result_m;

    fetch_stage u_fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .instr_d   (instr_d)
    );

    decode_stage u_decode (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .instr_d         (instr_d),
        .wb_write_enable (reg_write_w),
        .wb_write_addr   (dest_w),
        .wb_result       (result_w),
        .src_a_idx_d     (src_a_idx_d),
        .src_b_idx_d     (src_b_idx_d),
        .reg_write_e     (reg_write_e),
        .mem_write_e     (mem_write_e),
        .mem_to_reg_e    (mem_to_reg_e),
        .alu_src_imm_e   (alu_src_imm_e),
        .alu_op_e        (alu_op_e),
        .operand_a_e     (operand_a_e),
        .operand_b_e     (operand_b_e),
        .imm_e           (imm_e),
        .src_a_idx_e     (src_a_idx_e),
        .src_b_idx_e     (src_b_idx_e),
        .dest_e          (dest_e)
    );

    hazard_unit u_hazard (
        .src_a_idx_d  (src_a_idx_d),
        .src_b_idx_d  (src_b_idx_d),
        .src_a_idx_e  (src_a_idx_e),
        .src_b_idx_e  (src_b_idx_e),
        .dest_e       (dest_e),
        .dest_m       (dest_m),
        .dest_w       (dest_w),
        .mem_to_reg_e (mem_to_reg_e),
        .reg_write_m  (reg_write_m),
        .reg_write_w  (reg_write_w),
        .stall        (stall),
        .forward_a    (forward_a),
        .forward_b    (forward_b)
    );

    execute_stage u_execute (
        .clk              (clk),
        .reset            (reset),
        .reg_write_e      (reg_write_e),
        .mem_write_e      (mem_write_e),
        .mem_to_reg_e     (mem_to_reg_e),
        .alu_src_imm_e    (alu_src_imm_e),
        .alu_op_e         (alu_op_e),
        .operand_a_e      (operand_a_e),
        .operand_b_e      (operand_b_e),
        .imm_e            (imm_e),
        .dest_e           (dest_e),
        .forward_a        (forward_a),
        .forward_b        (forward_b),
        .alu_result_m_fwd (alu_result_m),
        .result_w_fwd     (result_w),
        .reg_write_m      (reg_write_m),
        .mem_write_m      (dmem_we),
        .mem_to_reg_m     (mem_to_reg_m),
        .alu_result_m     (alu_result_m),
        .store_data_m     (dmem_wdata),
        .dest_m           (dest_m)
    );

    memory_writeback u_memory_writeback (
        .clk          (clk),
        .reset        (reset),
        .reg_write_m  (reg_write_m),
        .mem_to_reg_m (mem_to_reg_m),
        .dest_m       (dest_m),
        .alu_result_m (alu_result_m),
        .dmem_rdata   (dmem_rdata),
        .reg_write_w  (reg_write_w),
        .dest_w       (dest_w),
        .result_w     (result_w)
    );

endmodule

// ==== source/register_file.sv ====
module register_file (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t read_addr_a,
    input  core_pkg::reg_addr_t read_addr_b,
    input  logic                write_enable,
    input  core_pkg::reg_addr_t write_addr,
    input  core_pkg::word_t     write_data,
    output core_pkg::word_t     read_data_a,
    output core_pkg::word_t     read_data_b
);

    // r0..r14 only
    core_pkg::word_t regs [0:core_pkg::zero_reg_read-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::zero_reg_read; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != core_pkg::zero_reg_read) begin
            regs[write_addr] <= write_data;
        end
    end

    // same-cycle write is visible to decode
    always_comb begin
        if (read_addr_a == core_pkg::zero_reg_read) begin
            read_data_a = '0;
        end else if (write_enable && write_addr == read_addr_a) begin
            read_data_a = write_data;
        end else begin
            read_data_a = regs[read_addr_a];
        end
    end

    always_comb begin
        if (read_addr_b == core_pkg::zero_reg_read) begin
            read_data_b = '0;
        end else if (write_enable && write_addr == read_addr_b) begin
            read_data_b = write_data;
        end else begin
            read_data_b = regs[read_addr_b];
        end
    end

endmodule

// ==== sources.f ====
source/core_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/hazard_unit.sv
source/pipeline_core.sv
verification/core_tb.sv
verification/core_asserts.sv

// ==== verification/core_asserts.sv ====
module core_asserts (
    input logic            clk,
    input logic            reset,
    input logic            stall,
    input core_pkg::word_t imem_addr,
    input logic            dmem_we
);
    timeunit 1ns;
    timeprecision 1ps;

    we_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(dmem_we))
        else $error("dmem_we is unknown");

    // fetch address frozen for the stalled cycle
    stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
                                     stall |=> $stable(imem_addr))
        else $error("imem_addr moved during a stall");

    single_stall: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
        else $error("stall high in two consecutive cycles");

endmodule

bind pipeline_core core_asserts u_core_asserts (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .imem_addr (imem_addr),
    .dmem_we   (dmem_we)
);

// ==== verification/core_tb.sv ====
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int imem_words    = 128;
    localparam int dmem_words    = 256;
    localparam int store_timeout = 200;
    // op field 11 decodes as a no-op
    localparam core_pkg::word_t nop_word = 32'hec00_0000;

    logic            clk;
    logic            reset;
    core_pkg::word_t imem_addr;
    core_pkg::word_t imem_data;
    core_pkg::word_t dmem_addr;
    core_pkg::word_t dmem_wdata;
    core_pkg::word_t dmem_rdata;
    logic            dmem_we;

    core_pkg::word_t imem [imem_words];
    core_pkg::word_t dmem [dmem_words];
    core_pkg::word_t program_words [$];
    core_pkg::word_t got_addr [$];
    core_pkg::word_t got_data [$];
    int              got_edge [$];
    core_pkg::word_t exp_addr [$];
    core_pkg::word_t exp_data [$];
    int              errors;
    int              edge_count;
    integer          seed;

    pipeline_core UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // memory models
    assign imem_data  = imem[imem_addr[8:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    function automatic core_pkg::word_t fill_word(input int index);
        return 32'hd000_0000 | core_pkg::word_t'(index * 4);
    endfunction

    // data memory write port that also logs each store with its edge number
    always @(posedge clk) begin
        if (reset) begin
            edge_count = 0;
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else begin
            edge_count = edge_count + 1;
            if (dmem_we) begin
                got_addr.push_back(dmem_addr);
                got_data.push_back(dmem_wdata);
                got_edge.push_back(edge_count);
                dmem[dmem_addr[9:2]] <= dmem_wdata;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction encoders with the condition field fixed at 1110
    function automatic core_pkg::word_t alu_imm(input logic [3:0] cmd, input logic [3:0] rd,
                                                input logic [3:0] rn, input logic [7:0] imm);
        return {4'he, 2'b00, 1'b1, cmd, 1'b0, rn, rd, 4'h0, imm};
    endfunction

    function automatic core_pkg::word_t alu_reg(input logic [3:0] cmd, input logic [3:0] rd,
                                                input logic [3:0] rn, input logic [3:0] rm);
        return {4'he, 2'b00, 1'b0, cmd, 1'b0, rn, rd, 8'h00, rm};
    endfunction

    function automatic core_pkg::word_t load_store(input logic load, input logic [3:0] rd,
                                                   input logic [3:0] rn, input logic [11:0] ofs);
        return {4'he, 2'b01, 1'b0, 4'b1100, load, rn, rd, ofs};
    endfunction

    // in-order instruction set model without a pipeline
    task automatic predict_stores();
        core_pkg::word_t regs [16];
        core_pkg::word_t mem [dmem_words];
        core_pkg::word_t instr;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t addr;
        logic [3:0]      rd;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = fill_word(i);
        end
        for (int i = 0; i < program_words.size(); i++) begin
            instr = program_words[i];
            rd    = instr[15:12];
            a     = regs[instr[19:16]];
            b     = instr[25] ? {24'h0, instr[7:0]} : regs[instr[3:0]];
            if (instr[27:26] == core_pkg::op_data && rd != 4'd15) begin
                case (instr[24:21])
                    core_pkg::cmd_and: regs[rd] = a & b;
                    core_pkg::cmd_sub: regs[rd] = a - b;
                    core_pkg::cmd_add: regs[rd] = a + b;
                    core_pkg::cmd_orr: regs[rd] = a | b;
                    core_pkg::cmd_mov: regs[rd] = b;
                    default: ;
                endcase
            end else if (instr[27:26] == core_pkg::op_memory) begin
                addr = a + {20'h0, instr[11:0]};
                if (!instr[20]) begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[rd]);
                    mem[addr[9:2]] = regs[rd];
                end else if (rd != 4'd15) begin
                    regs[rd] = mem[addr[9:2]];
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // run control
    task automatic start_program();
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = (i < program_words.size()) ? program_words[i] : nop_word;
        end
        predict_stores();
        repeat (2) @(posedge clk);
        got_addr.delete();
        got_data.delete();
        got_edge.delete();
        reset <= 1'b0;
    endtask

    task automatic finish_program();
        int waited;
        waited = 0;
        while (got_addr.size() < exp_addr.size() && waited < store_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (got_addr.size() < exp_addr.size()) begin
            errors++;
            $display("timed out after %0d cycles with %0d of %0d stores seen",
                     waited, got_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
            assert (got_addr[i] == exp_addr[i] && got_data[i] == exp_data[i]) else begin
                errors++;
                $display("Error %0t ns: store %0d wrote %h at %h, expected %h at %h",
                         $time, i, got_data[i], got_addr[i], exp_data[i], exp_addr[i]);
            end
        end
    endtask

    task automatic expect_store(input int index, input core_pkg::word_t addr,
                                input core_pkg::word_t data);
        assert (index < got_addr.size() && got_addr[index] == addr && got_data[index] == data)
        else begin
            errors++;
            $display("Error %0t ns: store %0d is not %h at %h", $time, index, data, addr);
        end
    endtask

    task automatic expect_edge(input int index, input int edge_number);
        assert (index < got_edge.size() && got_edge[index] == edge_number) else begin
            errors++;
            $display("Error %0t ns: store %0d not seen at edge %0d", $time, index, edge_number);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    task automatic check_reset_state();
        program_words = {alu_imm(core_pkg::cmd_mov, 4'd1, 4'd0, 8'd9), nop_word, nop_word,
                         load_store(1'b0, 4'd1, 4'd0, 12'd8)};
        start_program();
        @(negedge clk);
        assert (imem_addr == '0 && dmem_we == 1'b0) else begin
            errors++;
            $display("Error %0t ns: after reset imem_addr %h dmem_we %b",
                     $time, imem_addr, dmem_we);
        end
        finish_program();
        expect_store(0, 32'd8, 32'd9);
        // fourth instruction lands three edges after its fetch edge
        expect_edge(0, 7);
    endtask

    task automatic mem_stage_forwarding();
        program_words = {alu_imm(core_pkg::cmd_mov, 4'd1, 4'd0, 8'd5),
                         alu_imm(core_pkg::cmd_add, 4'd2, 4'd1, 8'd7),
                         load_store(1'b0, 4'd2, 4'd0, 12'd16)};
        start_program();
        finish_program();
        expect_store(0, 32'd16, 32'd12);
    endtask

    task automatic register_ops();
        program_words = {alu_imm(core_pkg::cmd_mov, 4'd1, 4'd0, 8'd12),
                         alu_imm(core_pkg::cmd_mov, 4'd2, 4'd0, 8'd10),
                         nop_word,
                         alu_reg(core_pkg::cmd_and, 4'd3, 4'd1, 4'd2),
                         alu_reg(core_pkg::cmd_orr, 4'd4, 4'd1, 4'd2),
                         alu_reg(core_pkg::cmd_sub, 4'd5, 4'd2, 4'd1),
                         load_store(1'b0, 4'd3, 4'd0, 12'd32),
                         load_store(1'b0, 4'd4, 4'd0, 12'd36),
                         load_store(1'b0, 4'd5, 4'd0, 12'd40)};
        start_program();
        finish_program();
        expect_store(0, 32'd32, 32'd8);
        expect_store(1, 32'd36, 32'd14);
        expect_store(2, 32'd40, 32'hffff_fffe);
    endtask

    task automatic load_use_stall();
        program_words = {alu_imm(core_pkg::cmd_mov, 4'd1, 4'd0, 8'd21),
                         load_store(1'b0, 4'd1, 4'd0, 12'd64),
                         load_store(1'b1, 4'd3, 4'd0, 12'd64),
                         alu_reg(core_pkg::cmd_add, 4'd4, 4'd3, 4'd3),
                         load_store(1'b0, 4'd4, 4'd0, 12'd68)};
        start_program();
        finish_program();
        expect_store(0, 32'd64, 32'd21);
        expect_store(1, 32'd68, 32'd42);
        // one bubble behind the load
        expect_edge(1, 9);
    endtask

    task automatic random_chain();
        int         kind;
        logic [3:0] rd;
        logic [3:0] rn;
        logic [3:0] cmd;
        logic [7:0] imm;
        program_words.delete();
        for (int i = 0; i < 20; i++) begin
            kind = int'($unsigned($random(seed)) % 3);
            rd   = 4'(1 + $unsigned($random(seed)) % 6);
            rn   = 4'(1 + $unsigned($random(seed)) % 6);
            imm  = 8'($random(seed));
            case (kind)
                0:       cmd = core_pkg::cmd_mov;
                1:       cmd = core_pkg::cmd_add;
                default: cmd = core_pkg::cmd_sub;
            endcase
            program_words.push_back(alu_imm(cmd, rd, rn, imm));
            program_words.push_back(load_store(1'b0, rd, 4'd0, 12'(256 + 4 * i)));
        end
        start_program();
        finish_program();
    endtask

    task automatic nop_handling();
        program_words = {alu_imm(core_pkg::cmd_mov, 4'd1, 4'd0, 8'd33),
                         alu_imm(core_pkg::cmd_mov, 4'd1, 4'd0, 8'd99) | 32'h0800_0000,
                         alu_imm(4'b1111, 4'd1, 4'd1, 8'd77),
                         alu_imm(core_pkg::cmd_mov, 4'd15, 4'd0, 8'd55),
                         load_store(1'b0, 4'd1, 4'd0, 12'd96),
                         load_store(1'b0, 4'd15, 4'd0, 12'd100)};
        start_program();
        finish_program();
        expect_store(0, 32'd96, 32'd33);
        expect_store(1, 32'd100, 32'd0);
    endtask

    initial begin
        clk    = 1'b0;
        reset <= 1'b1;
        errors = 0;
        seed   = 61;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = nop_word;
        end
        check_reset_state();
        mem_stage_forwarding();
        register_ops();
        load_use_stall();
        random_chain();
        nop_handling();
        $display("checks finished, error count %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
